/* design/lstm_num_pkg.sv */
package lstm_num_pkg;

	parameter int WIDTH = 32;
	parameter int FRAC  = 24;

	typedef logic signed [WIDTH-1:0] fixed_t;

	localparam fixed_t FX_ONE  = fixed_t'(1 << FRAC);
	localparam fixed_t FX_HALF = fixed_t'(1 << (FRAC - 1));

	// full product scaled back to q8.24
	function automatic fixed_t fx_mul(fixed_t a, fixed_t b);
		logic signed [2*WIDTH-1:0] p;
		p = a * b;
		return fixed_t'(p >>> FRAC);
	endfunction

	function automatic fixed_t hard_sigmoid(fixed_t x);
		fixed_t y;
		y = (x >>> 2) + FX_HALF; // x/4 + 0.5
		if (y < 0)
			return '0;
		else if (y > FX_ONE)
			return FX_ONE;
		else
			return y;
	endfunction

	function automatic fixed_t hard_tanh(fixed_t x);
		if (x > FX_ONE)
			return FX_ONE;
		else if (x < -FX_ONE)
			return -FX_ONE;
		else
			return x;
	endfunction

endpackage

/* design/lstm_ctrl_pkg.sv */
package lstm_ctrl_pkg;

	typedef enum logic [1:0] {
		GATE_A = 2'd0,
		GATE_I = 2'd1,
		GATE_F = 2'd2,
		GATE_O = 2'd3
	} gate_e;

	typedef enum logic [1:0] {
		TGT_W,
		TGT_U,
		TGT_B,
		TGT_X
	} target_e;

	typedef struct packed {
		logic                 valid;
		target_e              target;
		gate_e                gate;
		logic [7:0]           index;
		lstm_num_pkg::fixed_t data;
	} load_t;

	typedef struct packed {
		logic  start;
		gate_e gate;
	} mac_cmd_t;

	typedef struct packed {
		logic                 valid;
		gate_e                gate;
		lstm_num_pkg::fixed_t sum;
	} mac_res_t;

endpackage

/* design/gate_mac.sv */
`timescale 1ns/1ps

module gate_mac #(
	parameter int                   LEN     = 6,
	parameter lstm_ctrl_pkg::target_e WGT_TGT = lstm_ctrl_pkg::TGT_W
) (
	input  logic                    clk,
	input  logic                    i_rst,
	input  lstm_ctrl_pkg::load_t    i_load,
	input  lstm_ctrl_pkg::mac_cmd_t i_cmd,
	input  lstm_num_pkg::fixed_t    i_h,
	output lstm_ctrl_pkg::mac_res_t o_res
);
	import lstm_num_pkg::*;
	import lstm_ctrl_pkg::*;

	localparam int IDX_W = (LEN > 1) ? $clog2(LEN) : 1;
	localparam logic [IDX_W-1:0] LAST = IDX_W'(LEN - 1);

	fixed_t w_mem [4][LEN]; // one row per gate
	fixed_t operand;
	fixed_t prod;
	fixed_t acc;
	fixed_t sum_q;

	logic             run;
	logic [IDX_W-1:0] idx;
	gate_e            gate_q;
	logic             res_valid;

	always_ff @(posedge clk) begin
		if (i_load.valid && i_load.target == WGT_TGT && i_load.index < LEN) begin
			w_mem[i_load.gate][i_load.index[IDX_W-1:0]] <= i_load.data;
		end
	end

	if (WGT_TGT == TGT_W) begin : g_xmem
		fixed_t x_mem [LEN];

		always_ff @(posedge clk) begin
			if (i_load.valid && i_load.target == TGT_X && i_load.index < LEN) begin
				x_mem[i_load.index[IDX_W-1:0]] <= i_load.data;
			end
		end

		assign operand = x_mem[idx];
	end else begin : g_hop
		assign operand = i_h; // previous h on the recurrent path
	end

	assign prod = fx_mul(w_mem[gate_q][idx], operand);

	always_ff @(posedge clk) begin
		if (i_rst) begin
			run       <= 1'b0;
			idx       <= '0;
			gate_q    <= GATE_A;
			res_valid <= 1'b0;
		end else begin
			res_valid <= 1'b0;
			if (i_cmd.start) begin
				run    <= 1'b1;
				idx    <= '0;
				gate_q <= i_cmd.gate;
			end else if (run) begin
				if (idx == LAST) begin
					run       <= 1'b0;
					res_valid <= 1'b1;
				end else begin
					idx <= idx + 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (i_cmd.start) begin
			acc <= '0;
		end else if (run) begin
			acc <= acc + prod;
		end
		if (run && idx == LAST) begin
			sum_q <= acc + prod; // last term folded in
		end
	end

	assign o_res.valid = res_valid;
	assign o_res.gate  = gate_q;
	assign o_res.sum   = sum_q;

endmodule

/* design/cell_update.sv */
`timescale 1ns/1ps

module cell_update (
	input  logic                    clk,
	input  logic                    i_rst,
	input  lstm_ctrl_pkg::load_t    i_load,
	input  lstm_ctrl_pkg::mac_res_t i_x_res,
	input  lstm_ctrl_pkg::mac_res_t i_h_res,
	output logic                    o_gate_done,
	output logic                    o_step_done,
	output lstm_num_pkg::fixed_t    o_h,
	output lstm_num_pkg::fixed_t    o_c
);
	import lstm_num_pkg::*;
	import lstm_ctrl_pkg::*;

	fixed_t bias_mem [4];
	fixed_t act_q [4]; // activated a, i, f, o

	fixed_t x_sum_q;
	fixed_t h_sum_q;
	gate_e  x_gate_q;
	logic   x_pend;
	logic   h_pend;
	logic   upd_pend;

	logic   x_have;
	logic   h_have;
	logic   fire;
	gate_e  cur_gate;
	fixed_t x_sum;
	fixed_t h_sum;
	fixed_t pre;
	fixed_t act;
	fixed_t c_new;
	fixed_t h_new;

	// a result may be used in the cycle it arrives
	assign x_have   = x_pend | i_x_res.valid;
	assign h_have   = h_pend | i_h_res.valid;
	assign fire     = x_have & h_have;
	assign cur_gate = i_x_res.valid ? i_x_res.gate : x_gate_q;
	assign x_sum    = i_x_res.valid ? i_x_res.sum : x_sum_q;
	assign h_sum    = i_h_res.valid ? i_h_res.sum : h_sum_q;

	assign pre = x_sum + h_sum + bias_mem[cur_gate];
	assign act = (cur_gate == GATE_A) ? hard_tanh(pre) : hard_sigmoid(pre);

	assign c_new = fx_mul(act_q[GATE_F], o_c) + fx_mul(act_q[GATE_I], act_q[GATE_A]);
	assign h_new = fx_mul(act_q[GATE_O], hard_tanh(c_new));

	always_ff @(posedge clk) begin
		if (i_load.valid && i_load.target == TGT_B) begin
			bias_mem[i_load.gate] <= i_load.data;
		end
		if (i_x_res.valid) begin
			x_sum_q  <= i_x_res.sum;
			x_gate_q <= i_x_res.gate;
		end
		if (i_h_res.valid) begin
			h_sum_q <= i_h_res.sum;
		end
		if (fire) begin
			act_q[cur_gate] <= act;
		end
	end

	always_ff @(posedge clk) begin
		if (i_rst) begin
			x_pend      <= 1'b0;
			h_pend      <= 1'b0;
			upd_pend    <= 1'b0;
			o_gate_done <= 1'b0;
			o_step_done <= 1'b0;
			o_h         <= '0;
			o_c         <= '0;
		end else begin
			o_gate_done <= fire;
			upd_pend    <= fire && cur_gate == GATE_O; // o is the last gate
			o_step_done <= upd_pend;
			if (upd_pend) begin
				o_c <= c_new;
				o_h <= h_new;
			end
			if (fire) begin
				x_pend <= 1'b0;
				h_pend <= 1'b0;
			end else begin
				if (i_x_res.valid) begin
					x_pend <= 1'b1;
				end
				if (i_h_res.valid) begin
					h_pend <= 1'b1;
				end
			end
		end
	end

endmodule

/* design/lstm_step_fsm.sv */
`timescale 1ns/1ps

module lstm_step_fsm (
	input  logic                    clk,
	input  logic                    i_rst,
	input  logic                    i_start,
	input  logic                    i_gate_done,
	input  logic                    i_step_done,
	output lstm_ctrl_pkg::mac_cmd_t o_cmd,
	output logic                    o_busy,
	output logic                    o_done
);
	import lstm_ctrl_pkg::*;

	typedef enum logic [1:0] {
		S_IDLE,
		S_ISSUE,
		S_WAIT_GATE,
		S_WAIT_STEP
	} state_e;

	state_e state;
	gate_e  gate_q;

	always_ff @(posedge clk) begin
		if (i_rst) begin
			state  <= S_IDLE;
			gate_q <= GATE_A;
			o_done <= 1'b0;
		end else begin
			o_done <= 1'b0;
			case (state)
				S_IDLE: begin
					if (i_start) begin
						state  <= S_ISSUE;
						gate_q <= GATE_A;
					end
				end
				S_ISSUE: begin
					state <= S_WAIT_GATE; // start held one cycle
				end
				S_WAIT_GATE: begin
					if (i_gate_done) begin
						if (gate_q == GATE_O) begin
							state <= S_WAIT_STEP;
						end else begin
							gate_q <= gate_e'(gate_q + 2'd1);
							state  <= S_ISSUE;
						end
					end
				end
				S_WAIT_STEP: begin
					if (i_step_done) begin
						state  <= S_IDLE;
						o_done <= 1'b1;
					end
				end
				default: state <= S_IDLE;
			endcase
		end
	end

	assign o_cmd.start = (state == S_ISSUE);
	assign o_cmd.gate  = gate_q;
	assign o_busy      = (state != S_IDLE);

endmodule

/* design/lstm_cell_top.sv */
`timescale 1ns/1ps

module lstm_cell_top #(
	parameter int N_IN = 6
) (
	input  logic                 clk,
	input  logic                 i_rst,
	input  lstm_ctrl_pkg::load_t i_load,
	input  logic                 i_start,
	output logic                 o_busy,
	output logic                 o_done,
	output lstm_num_pkg::fixed_t o_h,
	output lstm_num_pkg::fixed_t o_c
);
	import lstm_ctrl_pkg::*;

	mac_cmd_t cmd;
	mac_res_t x_res;
	mac_res_t h_res;
	logic     gate_done;
	logic     step_done;

	gate_mac #(
		.LEN     (N_IN),
		.WGT_TGT (TGT_W)
	) x_mac_i (
		.clk    (clk),
		.i_rst  (i_rst),
		.i_load (i_load),
		.i_cmd  (cmd),
		.i_h    ('0), // x path reads its own operand memory
		.o_res  (x_res)
	);

	gate_mac #(
		.LEN     (1),
		.WGT_TGT (TGT_U)
	) h_mac_i (
		.clk    (clk),
		.i_rst  (i_rst),
		.i_load (i_load),
		.i_cmd  (cmd),
		.i_h    (o_h),
		.o_res  (h_res)
	);

	cell_update cell_update_i (
		.clk         (clk),
		.i_rst       (i_rst),
		.i_load      (i_load),
		.i_x_res     (x_res),
		.i_h_res     (h_res),
		.o_gate_done (gate_done),
		.o_step_done (step_done),
		.o_h         (o_h),
		.o_c         (o_c)
	);

	lstm_step_fsm step_fsm_i (
		.clk         (clk),
		.i_rst       (i_rst),
		.i_start     (i_start),
		.i_gate_done (gate_done),
		.i_step_done (step_done),
		.o_cmd       (cmd),
		.o_busy      (o_busy),
		.o_done      (o_done)
	);

endmodule

/* testbench/lstm_cell_asserts.sv */
`timescale 1ns/1ps

module lstm_cell_asserts (
	input logic                 clk,
	input logic                 i_rst,
	input lstm_ctrl_pkg::load_t i_load,
	input logic                 i_busy,
	input logic                 i_done
);

	// done closes a step as busy drops
	a_done_after_busy: assert property (
		@(posedge clk) disable iff (i_rst) i_done |-> $past(i_busy)
	) else $error("o_done high without o_busy in the previous cycle");

	a_no_load_busy: assert property (
		@(posedge clk) disable iff (i_rst) i_busy |-> !i_load.valid
	) else $error("load port written while a step is running");

	a_idle_after_reset: assert property (
		@(posedge clk) i_rst |=> !i_busy
	) else $error("o_busy high in the cycle after reset");

endmodule

/* testbench/lstm_cell_tb.sv */
`timescale 1ns/1ps

module lstm_cell_tb;
	import lstm_num_pkg::*;
	import lstm_ctrl_pkg::*;

	localparam int     N_IN     = 6;
	localparam int     STEP_CYC = 4 * (N_IN + 3) + 2;
	localparam int     TIMEOUT  = 200;
	localparam fixed_t ONE      = 32'sh0100_0000;

	logic   clk;
	logic   i_rst;
	load_t  i_load;
	logic   i_start;
	logic   o_busy;
	logic   o_done;
	fixed_t o_h;
	fixed_t o_c;

	fixed_t      w [4][N_IN];
	fixed_t      u [4];
	fixed_t      b [4];
	fixed_t      x [N_IN];
	fixed_t      ref_h;
	fixed_t      ref_c;
	logic [31:0] rng;
	int          errors;
	int          checks;
	int          tests;

	lstm_cell_top #(.N_IN(N_IN)) lstm_cell_top_i (
		.clk     (clk),
		.i_rst   (i_rst),
		.i_load  (i_load),
		.i_start (i_start),
		.o_busy  (o_busy),
		.o_done  (o_done),
		.o_h     (o_h),
		.o_c     (o_c)
	);

	bind lstm_cell_top lstm_cell_asserts asserts_i (
		.clk    (clk),
		.i_rst  (i_rst),
		.i_load (i_load),
		.i_busy (o_busy),
		.i_done (o_done)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// q8.24 product from bits 55..24 of the full result
	function automatic fixed_t q_mul(fixed_t a, fixed_t c);
		logic signed [63:0] full;
		full = {{32{a[31]}}, a} * {{32{c[31]}}, c};
		return full[55:24];
	endfunction

	function automatic fixed_t sigmoid_ref(fixed_t v);
		fixed_t q;
		q = {{2{v[31]}}, v[31:2]} + 32'sh0080_0000; // v/4 + 0.5
		if (q < 0)
			return '0;
		else if (q > ONE)
			return ONE;
		return q;
	endfunction

	function automatic fixed_t tanh_ref(fixed_t v);
		if (v > ONE)
			return ONE;
		else if (v < -ONE)
			return -ONE;
		return v;
	endfunction

	// small signed value of about +-0.5
	function automatic fixed_t next_small();
		rng = rng * 32'd1664525 + 32'd1013904223;
		return {{8{rng[23]}}, rng[23:0]};
	endfunction

	task automatic model_step();
		fixed_t act [4];
		fixed_t pre;
		fixed_t c_new;
		for (int g = 0; g < 4; g++) begin
			pre = b[g] + q_mul(u[g], ref_h);
			for (int k = 0; k < N_IN; k++)
				pre = pre + q_mul(w[g][k], x[k]);
			act[g] = (g == 0) ? tanh_ref(pre) : sigmoid_ref(pre);
		end
		c_new = q_mul(act[2], ref_c) + q_mul(act[1], act[0]);
		ref_h = q_mul(act[3], tanh_ref(c_new));
		ref_c = c_new;
	endtask

	task automatic load_word(target_e t, int g, int idx, fixed_t d);
		@(negedge clk);
		i_load.valid  = 1'b1;
		i_load.target = t;
		i_load.gate   = gate_e'(g);
		i_load.index  = 8'(idx);
		i_load.data   = d;
		@(negedge clk);
		i_load.valid = 1'b0;
	endtask

	task automatic load_inputs();
		for (int k = 0; k < N_IN; k++)
			load_word(TGT_X, 0, k, x[k]);
	endtask

	task automatic load_all();
		for (int g = 0; g < 4; g++) begin
			for (int k = 0; k < N_IN; k++)
				load_word(TGT_W, g, k, w[g][k]);
			load_word(TGT_U, g, 0, u[g]);
			load_word(TGT_B, g, 0, b[g]);
		end
		load_inputs();
	endtask

	task automatic compare_word(string name, logic [31:0] got, logic [31:0] exp);
		checks++;
		assert (got === exp) else begin
			$display("Mismatch %s: got %h expected %h", name, got, exp);
			errors++;
		end
	endtask

	task automatic run_step(output int cycles);
		@(negedge clk);
		i_start = 1'b1;
		cycles  = 0;
		do begin
			@(negedge clk);
			i_start = 1'b0;
			cycles++;
		end while (!o_done && cycles < TIMEOUT);
		checks++;
		assert (o_done) else begin
			$display("timeout: no o_done within %0d cycles of i_start", TIMEOUT);
			errors++;
		end
	endtask

	task automatic check_outputs();
		compare_word("o_h", o_h, ref_h);
		compare_word("o_c", o_c, ref_c);
	endtask

	task automatic finish_test(string name, int err0);
		tests++;
		$display("test %-14s %s (%0d errors)", name, (errors == err0) ? "ok" : "failed",
			errors - err0);
	endtask

	task automatic test_reset();
		int err0;
		err0  = errors;
		ref_h = '0;
		ref_c = '0;
		compare_word("o_busy", o_busy, 0);
		compare_word("o_done", o_done, 0);
		check_outputs();
		finish_test("reset", err0);
	endtask

	task automatic test_one_step();
		int err0;
		int cycles;
		err0 = errors;
		for (int g = 0; g < 4; g++) begin
			for (int k = 0; k < N_IN; k++)
				w[g][k] = fixed_t'(32'sh0020_0000 * (k - g)); // (k-g)/8
			u[g] = 32'sh0080_0000;
			b[g] = fixed_t'(32'sh0019_999a * g); // g/10
		end
		for (int k = 0; k < N_IN; k++)
			x[k] = fixed_t'(32'sh0040_0000 * (k + 1));
		load_all();
		run_step(cycles);
		compare_word("o_done latency", cycles, STEP_CYC);
		model_step();
		check_outputs();
		finish_test("one_step", err0);
	endtask

	task automatic test_recurrence();
		int err0;
		int cycles;
		err0 = errors;
		for (int g = 0; g < 4; g++) begin
			for (int k = 0; k < N_IN; k++)
				w[g][k] = next_small();
			u[g] = next_small();
			b[g] = next_small();
		end
		load_all();
		for (int s = 0; s < 4; s++) begin
			for (int k = 0; k < N_IN; k++)
				x[k] = next_small();
			load_inputs();
			run_step(cycles);
			model_step();
			check_outputs();
		end
		finish_test("recurrence", err0);
	endtask

	task automatic test_saturation();
		int     err0;
		int     cycles;
		fixed_t c_prev;
		err0   = errors;
		c_prev = ref_c;
		for (int g = 0; g < 4; g++) begin
			for (int k = 0; k < N_IN; k++)
				w[g][k] = (g == 0) ? 32'shfc00_0000 : 32'sh0400_0000; // -4.0 or 4.0
			u[g] = '0;
			b[g] = '0;
		end
		for (int k = 0; k < N_IN; k++)
			x[k] = ONE;
		load_all();
		run_step(cycles);
		model_step();
		check_outputs();
		compare_word("o_c step", o_c, c_prev - ONE); // i = f = 1, a = -1
		finish_test("saturation", err0);
	endtask

	task automatic test_start_busy();
		int err0;
		int cycles;
		int dones;
		err0   = errors;
		dones  = 0;
		cycles = 0;
		@(negedge clk);
		i_start = 1'b1;
		while (cycles < STEP_CYC + 40) begin
			@(negedge clk);
			i_start = (cycles == 5); // second pulse mid-step
			cycles++;
			if (o_done)
				dones++;
		end
		compare_word("o_done count", dones, 1);
		compare_word("o_busy", o_busy, 0);
		model_step();
		check_outputs();
		finish_test("start_busy", err0);
	endtask

	task automatic test_bias_only();
		int err0;
		int cycles;
		err0 = errors;
		for (int g = 0; g < 4; g++) begin
			for (int k = 0; k < N_IN; k++)
				w[g][k] = '0;
			u[g] = '0;
		end
		b[0] = 32'sh00c0_0000; // a = 0.75
		b[1] = 32'sh0080_0000; // i = 0.625
		b[2] = 32'shff00_0000; // f = 0.25
		b[3] = 32'sh0200_0000; // o = 1.0
		load_all();
		run_step(cycles);
		model_step();
		check_outputs();
		finish_test("bias_only", err0);
	endtask

	initial begin
		rng     = 32'hdbab;
		errors  = 0;
		checks  = 0;
		tests   = 0;
		i_rst   = 1'b1;
		i_start = 1'b0;
		i_load  = '0;
		repeat (10) @(negedge clk);
		i_rst = 1'b0;
		@(negedge clk);
		test_reset();
		test_one_step();
		test_recurrence();
		test_saturation();
		test_start_busy();
		test_bias_only();
		$display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
		if (errors == 0)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

endmodule

/* lstm_cell_top.f */
design/lstm_num_pkg.sv
design/lstm_ctrl_pkg.sv
design/gate_mac.sv
design/cell_update.sv
design/lstm_step_fsm.sv
design/lstm_cell_top.sv
testbench/lstm_cell_asserts.sv
testbench/lstm_cell_tb.sv
